/* hw/crate_bridge_pkg.sv */
package crate_bridge_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    // Front-end links behind the bridge
    localparam int unsigned NUM_LINKS = 4;
    localparam int unsigned LINK_IDX_W = 2;

    // Register space seen through one link
    localparam int unsigned LINK_ADDR_W = 25;
    localparam int unsigned DATA_W = 32;

    // Give up on a silent link after this many cycles
    localparam int unsigned TIMEOUT_CYCLES = 64;
    localparam int unsigned TIMER_W = 7;
    localparam logic [TIMER_W-1:0] TIMER_LIMIT = TIMER_W'(TIMEOUT_CYCLES);

    // Read data patterns on error responses
    localparam logic [DATA_W-1:0] BRIDGE_TIMEOUT_DATA = 32'hB1D6_E70F;
    localparam logic [DATA_W-1:0] BRIDGE_INVALID_DATA = 32'hB1D6_EBAD;

    //////////////////////////////
    // Types
    //////////////////////////////

    // One bit per link
    typedef logic [NUM_LINKS-1:0] link_mask_t;

    // PS register request, top address bits select the link
    typedef struct packed {
        logic                   wr;
        logic [LINK_IDX_W-1:0]  link;
        logic [LINK_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]      data;
    } reg_req_t;

    // PS register response
    typedef struct packed {
        logic              err;
        logic [DATA_W-1:0] data;
    } reg_rsp_t;

    // Command as it goes out on a link stream
    typedef struct packed {
        logic                   wr;
        logic [LINK_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]      data;
    } link_cmd_t;

    // Link response stream payload
    typedef struct packed {
        logic [DATA_W-1:0] data;
    } link_rsp_t;

    // What a channel hands to the merger when it finishes
    typedef struct packed {
        logic              timed_out;
        logic [DATA_W-1:0] data;
    } link_result_t;

endpackage

/* hw/bridge_dispatch.sv */
`timescale 1ns/1ns

module bridge_dispatch (
    input  logic                          ps_clk,
    input  logic                          arst_n_i,
    input  logic                          req_valid_i,
    input  crate_bridge_pkg::reg_req_t    req_i,
    input  crate_bridge_pkg::link_mask_t  link_up_i,
    input  logic                          rsp_valid_i,
    output logic                          busy_o,
    output crate_bridge_pkg::link_mask_t  start_o,
    output crate_bridge_pkg::link_mask_t  invalid_o,
    output crate_bridge_pkg::link_cmd_t   cmd_o
);

    logic                         accept;
    logic                         busy_q;
    logic                         pend_q;
    crate_bridge_pkg::link_mask_t sel_q;
    crate_bridge_pkg::link_mask_t invalid_q;
    crate_bridge_pkg::link_cmd_t  cmd_q;

    // Busy drops in the same cycle as the response pulse
    assign busy_o = busy_q & ~rsp_valid_i;
    assign accept = req_valid_i & ~busy_o;

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q    <= 1'b0;
            pend_q    <= 1'b0;
            sel_q     <= '0;
            invalid_q <= '0;
        end else begin
            pend_q <= accept;
            if (accept) begin
                busy_q <= 1'b1;
                sel_q  <= crate_bridge_pkg::link_mask_t'(1'b1) << req_i.link;
            end else if (rsp_valid_i) begin
                busy_q <= 1'b0;
            end
            // Refused request goes straight to the merger
            invalid_q <= pend_q ? (sel_q & ~link_up_i) : '0;
        end
    end

    // Request payload, held for the channel to capture
    always_ff @(posedge ps_clk) begin
        if (accept) begin
            cmd_q.wr   <= req_i.wr;
            cmd_q.addr <= req_i.addr;
            cmd_q.data <= req_i.data;
        end
    end

    // Link up level sampled once, in the cycle after the strobe
    assign start_o   = pend_q ? (sel_q & link_up_i) : '0;
    assign invalid_o = invalid_q;
    assign cmd_o     = cmd_q;

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Only one request in flight, the PS must wait for its answer
    a_no_req_while_busy: assert property (
        @(posedge ps_clk) disable iff (!arst_n_i)
        req_valid_i |-> !busy_o
    ) else $error("request strobe while bridge busy");

endmodule

/* hw/link_channel.sv */
`timescale 1ns/1ns

module link_channel (
    input  logic                           ps_clk,
    input  logic                           arst_n_i,
    input  logic                           start_i,
    input  crate_bridge_pkg::link_cmd_t    cmd_i,
    input  logic                           cmd_ready_i,
    input  logic                           link_rsp_valid_i,
    input  crate_bridge_pkg::link_rsp_t    link_rsp_i,
    output logic                           cmd_valid_o,
    output crate_bridge_pkg::link_cmd_t    cmd_o,
    output logic                           link_rsp_ready_o,
    output logic                           done_o,
    output crate_bridge_pkg::link_result_t result_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT
    } state_t;

    state_t                                state_q;
    logic [crate_bridge_pkg::TIMER_W-1:0]  timer_q;
    logic [crate_bridge_pkg::TIMER_W-1:0]  timer_nxt;
    logic                                  expired;
    logic                                  cmd_fire;
    logic                                  rsp_fire;
    logic                                  give_up;
    logic                                  fin_q;
    logic                                  done_q;
    crate_bridge_pkg::link_cmd_t           cmd_q;
    crate_bridge_pkg::link_result_t        result_q;

    assign cmd_valid_o      = (state_q == ST_ISSUE);
    assign link_rsp_ready_o = (state_q == ST_WAIT);

    assign cmd_fire = cmd_valid_o & cmd_ready_i;
    assign rsp_fire = link_rsp_valid_i & link_rsp_ready_o;

    // Timer covers both back-pressure and the response wait
    assign timer_nxt = timer_q + 1'b1;
    assign expired   = (timer_nxt >= crate_bridge_pkg::TIMER_LIMIT);

    // A handshake on the last cycle still counts
    assign give_up = expired & (((state_q == ST_ISSUE) & ~cmd_fire) |
                                ((state_q == ST_WAIT) & ~rsp_fire));

    //////////////////////////////
    // FSM
    //////////////////////////////

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
            timer_q <= '0;
            fin_q   <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            fin_q  <= 1'b0;
            done_q <= fin_q;
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        state_q <= ST_ISSUE;
                        timer_q <= '0;
                    end
                end
                ST_ISSUE: begin
                    timer_q <= timer_nxt;
                    if (cmd_fire) begin
                        state_q <= ST_WAIT;
                    end else if (give_up) begin
                        state_q <= ST_IDLE;
                        fin_q   <= 1'b1;
                    end
                end
                ST_WAIT: begin
                    timer_q <= timer_nxt;
                    if (rsp_fire || give_up) begin
                        state_q <= ST_IDLE;
                        fin_q   <= 1'b1;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Command and result payload
    always_ff @(posedge ps_clk) begin
        if ((state_q == ST_IDLE) && start_i) begin
            cmd_q <= cmd_i;
        end
        if (rsp_fire) begin
            result_q.timed_out <= 1'b0;
            result_q.data      <= link_rsp_i.data;
        end else if (give_up) begin
            result_q.timed_out <= 1'b1;
            result_q.data      <= crate_bridge_pkg::BRIDGE_TIMEOUT_DATA;
        end
    end

    assign cmd_o    = cmd_q;
    assign done_o   = done_q;
    assign result_o = result_q;

    // Command must stay offered and unchanged while the link holds off ready
    a_cmd_stable: assert property (
        @(posedge ps_clk) disable iff (!arst_n_i)
        (cmd_valid_o && !cmd_ready_i && !expired) |=> (cmd_valid_o && $stable(cmd_o))
    ) else $error("command dropped or changed under back-pressure");

endmodule

/* hw/bridge_merge.sv */
`timescale 1ns/1ns

module bridge_merge (
    input  logic                           ps_clk,
    input  logic                           arst_n_i,
    input  crate_bridge_pkg::link_mask_t   done_i,
    input  crate_bridge_pkg::link_result_t result_i [crate_bridge_pkg::NUM_LINKS],
    input  crate_bridge_pkg::link_mask_t   invalid_i,
    input  logic                           flags_clear_i,
    output logic                           rsp_valid_o,
    output crate_bridge_pkg::reg_rsp_t     rsp_o,
    output crate_bridge_pkg::link_mask_t   timeout_o,
    output crate_bridge_pkg::link_mask_t   invalid_o
);

    logic                         hit;
    crate_bridge_pkg::reg_rsp_t   rsp_nxt;
    crate_bridge_pkg::link_mask_t timeout_set;
    logic                         rsp_valid_q;
    crate_bridge_pkg::reg_rsp_t   rsp_q;
    crate_bridge_pkg::link_mask_t timeout_q;
    crate_bridge_pkg::link_mask_t invalid_q;

    assign hit = (|done_i) | (|invalid_i);

    // Invalid response unless a channel finished
    always_comb begin
        rsp_nxt.err  = 1'b1;
        rsp_nxt.data = crate_bridge_pkg::BRIDGE_INVALID_DATA;
        timeout_set  = '0;
        for (int n = 0; n < crate_bridge_pkg::NUM_LINKS; n++) begin
            if (done_i[n]) begin
                rsp_nxt.err    = result_i[n].timed_out;
                rsp_nxt.data   = result_i[n].data;
                timeout_set[n] = result_i[n].timed_out;
            end
        end
    end

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_q <= 1'b0;
            timeout_q   <= '0;
            invalid_q   <= '0;
        end else begin
            rsp_valid_q <= hit;
            // Sticky, a new error wins over a clear in the same cycle
            timeout_q <= (flags_clear_i ? '0 : timeout_q) | timeout_set;
            invalid_q <= (flags_clear_i ? '0 : invalid_q) | invalid_i;
        end
    end

    always_ff @(posedge ps_clk) begin
        if (hit) begin
            rsp_q <= rsp_nxt;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;
    assign timeout_o   = timeout_q;
    assign invalid_o   = invalid_q;

    // Dispatcher and channels never finish together
    a_single_source: assert property (
        @(posedge ps_clk) disable iff (!arst_n_i)
        $onehot0({done_i, invalid_i})
    ) else $error("more than one result source in one cycle");

endmodule

/* hw/crate_bridge_top.sv */
`timescale 1ns/1ns

module crate_bridge_top (
    input  logic                                     ps_clk,
    input  logic                                     arst_n_i,
    // PS register side
    input  logic                                     req_valid_i,
    input  crate_bridge_pkg::reg_req_t               req_i,
    output logic                                     busy_o,
    output logic                                     rsp_valid_o,
    output crate_bridge_pkg::reg_rsp_t               rsp_o,
    input  logic                                     flags_clear_i,
    output crate_bridge_pkg::link_mask_t             timeout_o,
    output crate_bridge_pkg::link_mask_t             invalid_o,
    // Link side
    input  crate_bridge_pkg::link_mask_t             link_up_i,
    output logic [crate_bridge_pkg::NUM_LINKS-1:0]   cmd_valid_o,
    output crate_bridge_pkg::link_cmd_t              cmd_o [crate_bridge_pkg::NUM_LINKS],
    input  logic [crate_bridge_pkg::NUM_LINKS-1:0]   cmd_ready_i,
    input  logic [crate_bridge_pkg::NUM_LINKS-1:0]   link_rsp_valid_i,
    input  crate_bridge_pkg::link_rsp_t              link_rsp_i [crate_bridge_pkg::NUM_LINKS],
    output logic [crate_bridge_pkg::NUM_LINKS-1:0]   link_rsp_ready_o
);

    crate_bridge_pkg::link_mask_t   start;
    crate_bridge_pkg::link_mask_t   invalid_pulse;
    crate_bridge_pkg::link_mask_t   done;
    crate_bridge_pkg::link_cmd_t    cmd_bcast;
    crate_bridge_pkg::link_result_t result [crate_bridge_pkg::NUM_LINKS];
    logic                           rsp_valid;

    bridge_dispatch bridge_dispatch_i (
        .ps_clk      (ps_clk),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .link_up_i   (link_up_i),
        .rsp_valid_i (rsp_valid),
        .busy_o      (busy_o),
        .start_o     (start),
        .invalid_o   (invalid_pulse),
        .cmd_o       (cmd_bcast)
    );

    // One channel per link, the start bit picks which one takes the command
    for (genvar n = 0; n < crate_bridge_pkg::NUM_LINKS; n++) begin : g_link
        link_channel link_channel_i (
            .ps_clk           (ps_clk),
            .arst_n_i         (arst_n_i),
            .start_i          (start[n]),
            .cmd_i            (cmd_bcast),
            .cmd_ready_i      (cmd_ready_i[n]),
            .link_rsp_valid_i (link_rsp_valid_i[n]),
            .link_rsp_i       (link_rsp_i[n]),
            .cmd_valid_o      (cmd_valid_o[n]),
            .cmd_o            (cmd_o[n]),
            .link_rsp_ready_o (link_rsp_ready_o[n]),
            .done_o           (done[n]),
            .result_o         (result[n])
        );
    end

    bridge_merge bridge_merge_i (
        .ps_clk        (ps_clk),
        .arst_n_i      (arst_n_i),
        .done_i        (done),
        .result_i      (result),
        .invalid_i     (invalid_pulse),
        .flags_clear_i (flags_clear_i),
        .rsp_valid_o   (rsp_valid),
        .rsp_o         (rsp_o),
        .timeout_o     (timeout_o),
        .invalid_o     (invalid_o)
    );

    assign rsp_valid_o = rsp_valid;

endmodule

/* verif/crate_bridge_tb.sv */
`timescale 1ns/1ns

module crate_bridge_tb;

    localparam int N = crate_bridge_pkg::NUM_LINKS;
    localparam int T = crate_bridge_pkg::TIMEOUT_CYCLES;
    // A request never needs more than a full timeout plus the pipeline
    localparam int REQ_LIMIT = T + 16;
    localparam int NUM_REQS = 10;
    localparam int WATCHDOG_NS = (NUM_REQS * (REQ_LIMIT + 8) + 40) * 40;

    logic                         ps_clk = 1'b0;
    logic                         arst_n = 1'b0;
    logic                         req_valid = 1'b0;
    crate_bridge_pkg::reg_req_t   req = '0;
    logic                         busy;
    logic                         rsp_valid;
    crate_bridge_pkg::reg_rsp_t   rsp;
    logic                         flags_clear = 1'b0;
    crate_bridge_pkg::link_mask_t timeout_flags;
    crate_bridge_pkg::link_mask_t invalid_flags;
    crate_bridge_pkg::link_mask_t link_up = '0;
    logic [N-1:0]                 cmd_valid;
    crate_bridge_pkg::link_cmd_t  cmd [N];
    wire  [N-1:0]                 cmd_ready;
    wire  [N-1:0]                 link_rsp_valid;
    crate_bridge_pkg::link_rsp_t  link_rsp [N];
    logic [N-1:0]                 link_rsp_ready;

    // Responder settings per link
    int                                  ready_delay [N];
    int                                  rsp_delay [N];
    logic [N-1:0]                        silent;
    logic [crate_bridge_pkg::DATA_W-1:0] rsp_data [N];

    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    logic [31:0] lfsr = 32'hd593_5ee4;

    always #20 ps_clk = ~ps_clk;

    crate_bridge_top crate_bridge_top_i (
        .ps_clk           (ps_clk),
        .arst_n_i         (arst_n),
        .req_valid_i      (req_valid),
        .req_i            (req),
        .busy_o           (busy),
        .rsp_valid_o      (rsp_valid),
        .rsp_o            (rsp),
        .flags_clear_i    (flags_clear),
        .timeout_o        (timeout_flags),
        .invalid_o        (invalid_flags),
        .link_up_i        (link_up),
        .cmd_valid_o      (cmd_valid),
        .cmd_o            (cmd),
        .cmd_ready_i      (cmd_ready),
        .link_rsp_valid_i (link_rsp_valid),
        .link_rsp_i       (link_rsp),
        .link_rsp_ready_o (link_rsp_ready)
    );

    //////////////////////////////
    // Link responders
    //////////////////////////////

    for (genvar n = 0; n < N; n++) begin : g_model
        logic                        ready = 1'b0;
        logic                        valid = 1'b0;
        logic                        pending = 1'b0;
        int                          cnt = 0;
        crate_bridge_pkg::link_rsp_t data = '0;

        assign cmd_ready[n]      = ready;
        assign link_rsp_valid[n] = valid;
        assign link_rsp[n]       = data;

        always @(posedge ps_clk) begin
            if (!arst_n || !(cmd_valid[n] || valid || pending)) begin
                ready   <= 1'b0;
                valid   <= 1'b0;
                pending <= 1'b0;
                cnt     <= 0;
            end else if (cmd_valid[n] && ready) begin
                // Command taken at this edge
                ready   <= 1'b0;
                pending <= !silent[n];
                cnt     <= 0;
            end else if (cmd_valid[n]) begin
                ready <= (cnt >= ready_delay[n]);
                cnt   <= cnt + 1;
            end else if (valid) begin
                valid <= !link_rsp_ready[n];
            end else if (cnt >= rsp_delay[n]) begin
                valid     <= 1'b1;
                pending   <= 1'b0;
                data.data <= rsp_data[n];
            end else begin
                cnt <= cnt + 1;
            end
        end
    end

    //////////////////////////////
    // Helpers and checks
    //////////////////////////////

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int width, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < width; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("Error: %s", msg);
    endtask

    task automatic check_rsp(input string name, input crate_bridge_pkg::reg_rsp_t exp,
                             input crate_bridge_pkg::reg_rsp_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s response: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_cmd(input string name, input crate_bridge_pkg::link_cmd_t exp,
                             input crate_bridge_pkg::link_cmd_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s command: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flags(input string name, input string what,
                               input crate_bridge_pkg::link_mask_t exp,
                               input crate_bridge_pkg::link_mask_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s %s: expected %b, actual %b", name, what, exp, act);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    // Link levels and one responder's behavior for the next request
    task automatic setup(input crate_bridge_pkg::link_mask_t up, input int n,
                         input int rdy, input int rd, input logic quiet);
        logic [31:0] v;
        take_bits(32, v);
        @(posedge ps_clk);
        link_up        <= up;
        ready_delay[n] <= rdy;
        rsp_delay[n]   <= rd;
        silent[n]      <= quiet;
        rsp_data[n]    <= v;
    endtask

    task automatic random_req(input int n, input logic wr,
                              output crate_bridge_pkg::reg_req_t r);
        logic [31:0] v;
        r.wr   = wr;
        r.link = crate_bridge_pkg::LINK_IDX_W'(n);
        take_bits(crate_bridge_pkg::LINK_ADDR_W, v);
        r.addr = v[crate_bridge_pkg::LINK_ADDR_W-1:0];
        take_bits(32, v);
        r.data = v;
    endtask

    task automatic clear_flags();
        @(posedge ps_clk);
        flags_clear <= 1'b1;
        @(posedge ps_clk);
        flags_clear <= 1'b0;
        @(posedge ps_clk);
    endtask

    // Strobe at edge S, then sample at each later edge; rsp_k counts edges after S
    task automatic run_request(input string name, input crate_bridge_pkg::reg_req_t r,
                               output crate_bridge_pkg::reg_rsp_t got,
                               output int rsp_k, output int rise_k);
        int                          n;
        int                          k;
        logic [N-1:0]                other;
        crate_bridge_pkg::link_cmd_t exp_cmd;
        n = r.link;
        exp_cmd.wr   = r.wr;
        exp_cmd.addr = r.addr;
        exp_cmd.data = r.data;
        rsp_k  = -1;
        rise_k = -1;
        got    = '0;
        k      = 0;
        @(posedge ps_clk);
        req_valid <= 1'b1;
        req       <= r;
        @(posedge ps_clk);
        req_valid <= 1'b0;
        while (rsp_k < 0 && k < REQ_LIMIT) begin
            @(posedge ps_clk);
            k++;
            other    = cmd_valid;
            other[n] = 1'b0;
            if (|other) report_error({name, ": command raised on another link"});
            if (cmd_valid[n]) begin
                if (rise_k < 0) rise_k = k;
                check_cmd(name, exp_cmd, cmd[n]);
            end
            other    = link_rsp_ready;
            other[n] = 1'b0;
            if (|other) report_error({name, ": response ready raised on another link"});
            if (link_rsp_ready[n] && (cmd_valid[n] || rise_k < 0)) begin
                report_error({name, ": response ready before the command was taken"});
            end
            if (rsp_valid) begin
                rsp_k = k;
                got   = rsp;
                if (busy) report_error({name, ": busy still high with the response"});
                if (|link_rsp_ready) begin
                    report_error({name, ": response ready still high with the response"});
                end
            end else if (!busy) begin
                report_error({name, ": busy dropped before the response"});
            end
        end
        if (rsp_k < 0) report_error({name, ": bridge gave no response"});
    endtask

    task automatic ok_request(input string name, input int n, input logic wr,
                              input int rdy, input int rd);
        crate_bridge_pkg::reg_req_t r;
        crate_bridge_pkg::reg_rsp_t got;
        crate_bridge_pkg::reg_rsp_t exp;
        int                         rsp_k;
        int                         rise_k;
        setup(4'b1111, n, rdy, rd, 1'b0);
        random_req(n, wr, r);
        run_request(name, r, got, rsp_k, rise_k);
        exp.err  = 1'b0;
        exp.data = rsp_data[n];
        check_rsp(name, exp, got);
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic test_reads();
        int e = errors;
        for (int n = 0; n < N; n++) begin
            ok_request("read", n, 1'b0, n, 3 - n);
        end
        finish_test("read on each link", e);
    endtask

    task automatic test_write();
        int e = errors;
        ok_request("write", 2, 1'b1, 1, 1);
        finish_test("write", e);
    endtask

    task automatic test_backpressure();
        int e = errors;
        // Ready held low well below the timeout
        ok_request("back-pressure", 3, 1'b1, 30, 2);
        finish_test("back-pressure", e);
    endtask

    task automatic fail_request(input string name, input int n, input logic up,
                                input crate_bridge_pkg::link_mask_t exp_to,
                                input crate_bridge_pkg::link_mask_t exp_inv);
        crate_bridge_pkg::reg_req_t r;
        crate_bridge_pkg::reg_rsp_t got;
        crate_bridge_pkg::reg_rsp_t exp;
        crate_bridge_pkg::link_mask_t lvl;
        int                         rsp_k;
        int                         rise_k;
        lvl    = '1;
        lvl[n] = up;
        setup(lvl, n, 0, 0, 1'b1);
        random_req(n, 1'b0, r);
        run_request(name, r, got, rsp_k, rise_k);
        exp.err  = 1'b1;
        exp.data = up ? crate_bridge_pkg::BRIDGE_TIMEOUT_DATA
                      : crate_bridge_pkg::BRIDGE_INVALID_DATA;
        check_rsp(name, exp, got);
        if (!up) begin
            if (rise_k >= 0) report_error({name, ": command sent to a link that is down"});
            if (rsp_k != 3) begin
                errors++;
                $display("Fail %s latency: expected 2, actual %0d", name, rsp_k - 1);
            end
        end else if (rise_k < 0 || rsp_k - rise_k < T || rsp_k - rise_k > T + 3) begin
            report_error({name, ": timeout response outside the allowed window"});
        end
        check_flags(name, "timeout mask", exp_to, timeout_flags);
        check_flags(name, "invalid mask", exp_inv, invalid_flags);
    endtask

    task automatic test_link_down();
        int e = errors;
        clear_flags();
        fail_request("link down", 2, 1'b0, 4'b0000, 4'b0100);
        finish_test("link down", e);
    endtask

    task automatic test_timeout();
        int e = errors;
        fail_request("timeout", 1, 1'b1, 4'b0010, 4'b0100);
        finish_test("timeout", e);
    endtask

    task automatic test_flag_clear();
        int e = errors;
        clear_flags();
        check_flags("flag clear", "timeout mask", '0, timeout_flags);
        check_flags("flag clear", "invalid mask", '0, invalid_flags);
        fail_request("flag clear", 0, 1'b0, 4'b0000, 4'b0001);
        fail_request("flag clear", 3, 1'b1, 4'b1000, 4'b0001);
        finish_test("flag clear", e);
    endtask

    initial begin
        for (int n = 0; n < N; n++) begin
            ready_delay[n] = 0;
            rsp_delay[n]   = 0;
            rsp_data[n]    = '0;
        end
        silent = '0;
        repeat (2) @(posedge ps_clk);
        arst_n <= 1'b1;
        test_reads();
        test_write();
        test_link_down();
        test_timeout();
        test_backpressure();
        test_flag_clear();
        repeat (4) @(posedge ps_clk);
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* files.f */
hw/crate_bridge_pkg.sv
hw/bridge_dispatch.sv
hw/link_channel.sv
hw/bridge_merge.sv
hw/crate_bridge_top.sv
verif/crate_bridge_tb.sv

/* Bender.yml */
package:
  name: crate_bridge

sources:
  - hw/crate_bridge_pkg.sv
  - hw/bridge_dispatch.sv
  - hw/link_channel.sv
  - hw/bridge_merge.sv
  - hw/crate_bridge_top.sv
  - target: test
    files:
      - verif/crate_bridge_tb.sv
